/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = mipsCoreTb
RTL_TOP   = mipsCore
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
rtl/mipsPkg.sv
rtl/regFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memWbStage.sv
rtl/mipsCore.sv
tb/coreMonitor.sv
tb/mipsCoreTb.sv

/* rtl/decodeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeStage import mipsPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  word_t    idInstr,
    input  word_t    idPc,
    input  regAddr_t exDest,
    input  logic     exRegWrite,
    input  logic     exMemRead,
    input  word_t    exFwd,
    input  regAddr_t memDest,
    input  logic     memRegWrite,
    input  word_t    memFwd,
    input  logic     wbValid,
    input  regAddr_t wbAddr,
    input  word_t    wbData,
    output logic     stall,
    output logic     branchTaken,
    output word_t    branchTarget,
    output word_t    exOpA,
    output word_t    exOpB,
    output word_t    exImm,
    output word_t    exLink,
    output regAddr_t exShamt,
    output aluOp_t   exAluOp,
    output wbSrc_t   exWbSrc,
    output logic     exRegWriteOut,
    output logic     exMemReadOut,
    output logic     exMemWriteOut,
    output logic     exUseImm,
    output regAddr_t exDestOut
);
    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr_t   rs, rt, rd, dest;
    word_t      rsRaw, rtRaw, rsVal, rtVal, immExt, pcPlus4;
    aluOp_t     aluOp;
    wbSrc_t     wbSrc;
    logic       regWrite, memRead, memWrite, useImm, signExt;
    logic       destRt, destLink, isBeq, isBne, isJump, isJr;

    assign opcode = idInstr[31:26];
    assign funct  = idInstr[5:0];
    assign rs     = idInstr[25:21];
    assign rt     = idInstr[20:16];
    assign rd     = idInstr[15:11];

    always_comb begin
        aluOp = aluAdd;
        wbSrc = wbAlu;
        {regWrite, memRead, memWrite, destLink} = 4'b0000;
        {isBeq, isBne, isJump, isJr} = 4'b0000;
        useImm  = 1'b1;
        signExt = 1'b1;
        destRt  = 1'b1;
        case (opcode)
            opRtype: begin
                useImm   = 1'b0;
                destRt   = 1'b0;
                regWrite = 1'b1;
                case (funct)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnNor:   aluOp = aluNor;
                    fnSlt:   aluOp = aluSlt;
                    fnSltu:  aluOp = aluSltu;
                    fnSll:   aluOp = aluSll;
                    fnSrl:   aluOp = aluSrl;
                    fnJr: begin
                        regWrite = 1'b0;
                        isJr     = 1'b1;
                    end
                    default: regWrite = 1'b0; // unknown funct runs as nop
                endcase
            end
            opAddiu: regWrite = 1'b1;
            opSlti: begin
                regWrite = 1'b1;
                aluOp    = aluSlt;
            end
            opAndi: begin
                regWrite = 1'b1;
                signExt  = 1'b0;
                aluOp    = aluAnd;
            end
            opOri: begin
                regWrite = 1'b1;
                signExt  = 1'b0;
                aluOp    = aluOr;
            end
            opLui: begin
                regWrite = 1'b1;
                signExt  = 1'b0;
                aluOp    = aluLui;
            end
            opLw: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                wbSrc    = wbLoad;
            end
            opSw:    memWrite = 1'b1;
            opBeq:   isBeq = 1'b1;
            opBne:   isBne = 1'b1;
            opJ:     isJump = 1'b1;
            opJal: begin
                isJump   = 1'b1;
                regWrite = 1'b1;
                destLink = 1'b1;
                wbSrc    = wbLink;
            end
            default: ;
        endcase
    end

    assign dest   = destLink ? linkReg : (destRt ? rt : rd);
    assign immExt = signExt ? {{16{idInstr[15]}}, idInstr[15:0]} : {16'h0, idInstr[15:0]};

    regFile regFile_i (
        .clk    (clk),
        .arstN  (arstN),
        .rsAddr (rs),
        .rtAddr (rt),
        .rsData (rsRaw),
        .rtData (rtRaw),
        .we     (wbValid),
        .wAddr  (wbAddr),
        .wData  (wbData)
    );

    // youngest producer wins
    assign rsVal = (rs != '0 && exRegWrite && exDest == rs)   ? exFwd  :
                   (rs != '0 && memRegWrite && memDest == rs) ? memFwd : rsRaw;
    assign rtVal = (rt != '0 && exRegWrite && exDest == rt)   ? exFwd  :
                   (rt != '0 && memRegWrite && memDest == rt) ? memFwd : rtRaw;

    // load data only exists from MEM onwards
    assign stall = exMemRead && exDest != '0 && (exDest == rs || exDest == rt);

    assign pcPlus4     = idPc + word_t'(4);
    assign branchTaken = (isBeq && rsVal == rtVal) || (isBne && rsVal != rtVal) || isJump || isJr;

    always_comb begin
        if (isJr) begin
            branchTarget = rsVal;
        end else if (isJump) begin
            branchTarget = {pcPlus4[31:28], idInstr[25:0], 2'b00};
        end else begin
            branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exRegWriteOut <= 1'b0;
            exMemReadOut  <= 1'b0;
            exMemWriteOut <= 1'b0;
            exDestOut     <= '0;
        end else begin
            exRegWriteOut <= regWrite && !stall; // bubble on load-use
            exMemReadOut  <= memRead && !stall;
            exMemWriteOut <= memWrite && !stall;
            exDestOut     <= dest;
        end
    end

    always_ff @(posedge clk) begin
        exOpA    <= rsVal;
        exOpB    <= rtVal;
        exImm    <= immExt;
        exLink   <= idPc + word_t'(8);
        exShamt  <= idInstr[10:6];
        exAluOp  <= aluOp;
        exWbSrc  <= wbSrc;
        exUseImm <= useImm;
    end

endmodule

`default_nettype wire

/* rtl/executeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module executeStage import mipsPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  word_t    exOpA,
    input  word_t    exOpB,
    input  word_t    exImm,
    input  word_t    exLink,
    input  regAddr_t exShamt,
    input  aluOp_t   exAluOp,
    input  wbSrc_t   exWbSrc,
    input  logic     exRegWrite,
    input  logic     exMemRead,
    input  logic     exMemWrite,
    input  logic     exUseImm,
    input  regAddr_t exDest,
    output word_t    fwdValue,
    output word_t    memAddr,
    output word_t    memStoreData,
    output regAddr_t memDest,
    output logic     memRegWrite,
    output logic     memRead,
    output logic     memWrite,
    output wbSrc_t   memWbSrc,
    output word_t    memLink
);
    word_t srcA;
    word_t srcB;
    word_t aluResult;

    assign srcA = (exAluOp == aluSll || exAluOp == aluSrl) ? word_t'(exShamt) : exOpA;
    assign srcB = exUseImm ? exImm : exOpB;

    always_comb begin
        case (exAluOp)
            aluAdd:  aluResult = srcA + srcB;
            aluSub:  aluResult = srcA - srcB;
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            aluXor:  aluResult = srcA ^ srcB;
            aluNor:  aluResult = ~(srcA | srcB);
            aluSlt:  aluResult = word_t'($signed(srcA) < $signed(srcB));
            aluSltu: aluResult = word_t'(srcA < srcB);
            aluSll:  aluResult = srcB << srcA[regAddrW-1:0];
            aluSrl:  aluResult = srcB >> srcA[regAddrW-1:0];
            aluLui:  aluResult = {srcB[15:0], 16'h0};
            default: aluResult = '0;
        endcase
    end

    // meaningless for a load since decode stalls on that case
    assign fwdValue = (exWbSrc == wbLink) ? exLink : aluResult;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memRegWrite <= 1'b0;
            memRead     <= 1'b0;
            memWrite    <= 1'b0;
            memDest     <= '0;
        end else begin
            memRegWrite <= exRegWrite;
            memRead     <= exMemRead;
            memWrite    <= exMemWrite;
            memDest     <= exDest;
        end
    end

    always_ff @(posedge clk) begin
        memAddr      <= aluResult; // also the result for non-memory ops
        memStoreData <= exOpB;
        memWbSrc     <= exWbSrc;
        memLink      <= exLink;
    end

endmodule

`default_nettype wire

/* rtl/fetchStage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchStage import mipsPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  stall,
    input  logic  branchTaken,
    input  word_t branchTarget,
    output word_t imemAddr,
    input  word_t imemData,
    output word_t idInstr,
    output word_t idPc
);
    word_t pc;
    word_t nextPc;

    assign imemAddr = pc;
    // the delay slot is in flight while the branch decodes, so the target comes next
    assign nextPc = branchTaken ? branchTarget : pc + word_t'(4);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc      <= resetPc;
            idInstr <= '0;        // sll $0 acts as bubble
            idPc    <= resetPc;
        end else if (!stall) begin
            pc      <= nextPc;
            idInstr <= imemData;
            idPc    <= pc;
        end
    end

endmodule

`default_nettype wire

/* rtl/memWbStage.sv */
`timescale 1ns/10ps
`default_nettype none

module memWbStage import mipsPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  word_t    memAddr,
    input  word_t    memStoreData,
    input  regAddr_t memDest,
    input  logic     memRegWrite,
    input  logic     memRead,
    input  logic     memWrite,
    input  wbSrc_t   memWbSrc,
    input  word_t    memLink,
    output word_t    dmemAddr,
    output word_t    dmemWdata,
    output logic     dmemWe,
    input  word_t    dmemRdata,
    output word_t    fwdValue,
    output logic     wbValid,
    output regAddr_t wbAddr,
    output word_t    wbData
);
    word_t    resultSel;
    word_t    resultQ;
    word_t    loadQ;
    wbSrc_t   wbSrcQ;
    logic     regWriteQ;
    regAddr_t destQ;

    assign dmemAddr  = memAddr;
    assign dmemWdata = memStoreData;
    assign dmemWe    = memWrite;

    assign resultSel = (memWbSrc == wbLink) ? memLink : memAddr;
    assign fwdValue  = memRead ? dmemRdata : resultSel; // memory answers in the same cycle

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regWriteQ <= 1'b0;
            destQ     <= '0;
            wbSrcQ    <= wbAlu;
        end else begin
            regWriteQ <= memRegWrite;
            destQ     <= memDest;
            wbSrcQ    <= memWbSrc;
        end
    end

    always_ff @(posedge clk) begin
        resultQ <= resultSel;
        if (memRead) begin
            loadQ <= dmemRdata;
        end
    end

    assign wbValid = regWriteQ && destQ != '0; // $0 never written
    assign wbAddr  = destQ;
    assign wbData  = (wbSrcQ == wbLoad) ? loadQ : resultQ;

endmodule

`default_nettype wire

/* rtl/mipsCore.sv */
`timescale 1ns/10ps
`default_nettype none

module mipsCore import mipsPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    output word_t    imemAddr,
    input  word_t    imemData,
    output word_t    dmemAddr,
    output word_t    dmemWdata,
    output logic     dmemWe,
    input  word_t    dmemRdata,
    output logic     wbValid,
    output regAddr_t wbAddr,
    output word_t    wbData
);
    word_t    idInstr, idPc, branchTarget;
    logic     stall, branchTaken;
    // ID/EX
    word_t    exOpA, exOpB, exImm, exLink, exFwd;
    regAddr_t exShamt, exDest;
    aluOp_t   exAluOp;
    wbSrc_t   exWbSrc;
    logic     exRegWrite, exMemRead, exMemWrite, exUseImm;
    // EX/MEM
    word_t    memAddr, memStoreData, memLink, memFwd;
    regAddr_t memDest;
    logic     memRegWrite, memRead, memWrite;
    wbSrc_t   memWbSrc;

    fetchStage fetchStage_i (
        .clk (clk), .arstN (arstN),
        .stall (stall), .branchTaken (branchTaken), .branchTarget (branchTarget),
        .imemAddr (imemAddr), .imemData (imemData),
        .idInstr (idInstr), .idPc (idPc)
    );

    decodeStage decodeStage_i (
        .clk (clk), .arstN (arstN),
        .idInstr (idInstr), .idPc (idPc),
        .exDest (exDest), .exRegWrite (exRegWrite), .exMemRead (exMemRead),
        .exFwd (exFwd),
        .memDest (memDest), .memRegWrite (memRegWrite), .memFwd (memFwd),
        .wbValid (wbValid), .wbAddr (wbAddr), .wbData (wbData),
        .stall (stall), .branchTaken (branchTaken), .branchTarget (branchTarget),
        .exOpA (exOpA), .exOpB (exOpB), .exImm (exImm), .exLink (exLink),
        .exShamt (exShamt), .exAluOp (exAluOp), .exWbSrc (exWbSrc),
        .exRegWriteOut (exRegWrite),   // fed back for hazard checks
        .exMemReadOut (exMemRead),
        .exMemWriteOut (exMemWrite),
        .exUseImm (exUseImm),
        .exDestOut (exDest)
    );

    executeStage executeStage_i (
        .clk (clk), .arstN (arstN),
        .exOpA (exOpA), .exOpB (exOpB), .exImm (exImm), .exLink (exLink),
        .exShamt (exShamt), .exAluOp (exAluOp), .exWbSrc (exWbSrc),
        .exRegWrite (exRegWrite), .exMemRead (exMemRead), .exMemWrite (exMemWrite),
        .exUseImm (exUseImm), .exDest (exDest),
        .fwdValue (exFwd),
        .memAddr (memAddr), .memStoreData (memStoreData), .memDest (memDest),
        .memRegWrite (memRegWrite), .memRead (memRead), .memWrite (memWrite),
        .memWbSrc (memWbSrc), .memLink (memLink)
    );

    memWbStage memWbStage_i (
        .clk (clk), .arstN (arstN),
        .memAddr (memAddr), .memStoreData (memStoreData), .memDest (memDest),
        .memRegWrite (memRegWrite), .memRead (memRead), .memWrite (memWrite),
        .memWbSrc (memWbSrc), .memLink (memLink),
        .dmemAddr (dmemAddr), .dmemWdata (dmemWdata), .dmemWe (dmemWe),
        .dmemRdata (dmemRdata),
        .fwdValue (memFwd),
        .wbValid (wbValid), .wbAddr (wbAddr), .wbData (wbData)
    );

endmodule

`default_nettype wire

/* rtl/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    localparam int wordW    = 32;
    localparam int regAddrW = 5;

    typedef logic [wordW-1:0]    word_t;
    typedef logic [regAddrW-1:0] regAddr_t;

    // primary opcodes in instr[31:26]
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opSlti  = 6'h0a;
    localparam logic [5:0] opAndi  = 6'h0c;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // funct field of R-type in instr[5:0]
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluLui
    } aluOp_t;

    typedef enum logic [1:0] {wbAlu, wbLink, wbLoad} wbSrc_t;

    localparam regAddr_t linkReg = 5'd31; // jal destination
    localparam word_t    resetPc = '0;

endpackage

`default_nettype wire

/* rtl/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile import mipsPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  regAddr_t rsAddr,
    input  regAddr_t rtAddr,
    output word_t    rsData,
    output word_t    rtData,
    input  logic     we,
    input  regAddr_t wAddr,
    input  word_t    wData
);
    word_t regs [2**regAddrW];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**regAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    // same-cycle write shows through to the read ports
    assign rsData = (rsAddr == '0) ? '0 :
                    (we && wAddr == rsAddr) ? wData : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 :
                    (we && wAddr == rtAddr) ? wData : regs[rtAddr];

endmodule

`default_nettype wire

/* tb/coreMonitor.sv */
`timescale 1ns/10ps
`default_nettype none

module coreMonitor import mipsPkg::*; #(
    parameter int traceDepth = 128
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic [67:0] trace [traceDepth],
    input  word_t       imemAddr,
    input  logic        wbValid,
    input  regAddr_t    wbAddr,
    input  word_t       wbData,
    input  logic        dmemWe,
    input  word_t       dmemAddr,
    input  word_t       dmemWdata,
    output int          wbSeen,
    output int          storeSeen,
    output int          errCount
);
    localparam logic [3:0] tagWb     = 4'h2;
    localparam logic [3:0] tagStore  = 4'h3;
    localparam word_t      startAddr = 32'h0000_0000;

    int   wbPtr;
    int   storePtr;
    int   cyclesOut;
    logic outOfReset; // arstN as seen at the rising edge

    function automatic int findNext(input int from, input logic [3:0] tag);
        int idx;
        idx = from;
        while (idx < traceDepth && trace[idx][67:64] != tag) begin
            idx++;
        end
        return idx;
    endfunction

    task automatic checkWriteback();
        int idx;
        idx = findNext(wbPtr + 1, tagWb);
        if (idx >= traceDepth) begin
            $display("unexpected writeback of %h to r%0d after the last expected one",
                     wbData, wbAddr);
            errCount++;
        end else begin
            if (wbAddr != trace[idx][36:32] || wbData != trace[idx][31:0]) begin
                $display("ERR writeback%0d expected r%0d=%h actual r%0d=%h", wbSeen,
                         trace[idx][36:32], trace[idx][31:0], wbAddr, wbData);
                errCount++;
            end
            wbPtr = idx;
            wbSeen++;
        end
    endtask

    task automatic checkStore();
        int idx;
        idx = findNext(storePtr + 1, tagStore);
        if (idx >= traceDepth) begin
            $display("unexpected store of %h to %h after the last expected one",
                     dmemWdata, dmemAddr);
            errCount++;
        end else begin
            if (dmemAddr != trace[idx][63:32] || dmemWdata != trace[idx][31:0]) begin
                $display("ERR store%0d expected [%h]=%h actual [%h]=%h", storeSeen,
                         trace[idx][63:32], trace[idx][31:0], dmemAddr, dmemWdata);
                errCount++;
            end
            storePtr = idx;
            storeSeen++;
        end
    endtask

    initial begin
        wbSeen     = 0;
        storeSeen  = 0;
        errCount   = 0;
        wbPtr      = -1;
        storePtr   = -1;
        cyclesOut  = 0;
        outOfReset = 1'b0;
    end

    always @(posedge clk) begin
        outOfReset <= arstN;
    end

    // outputs are settled mid-cycle
    always @(negedge clk) begin
        if (!outOfReset) begin
            if (wbValid || dmemWe) begin
                $display("a writeback or store was active while reset was asserted");
                errCount++;
            end
            if (imemAddr != startAddr) begin
                $display("ERR resetFetch expected %h actual %h", startAddr, imemAddr);
                errCount++;
            end
        end else begin
            if (cyclesOut == 0 && imemAddr != startAddr + 32'd4) begin
                $display("ERR fetchStep expected %h actual %h",
                         startAddr + 32'd4, imemAddr);
                errCount++;
            end
            cyclesOut++;
            if (wbValid) begin
                checkWriteback();
            end
            if (dmemWe) begin
                checkStore();
            end
        end
    end

endmodule

`default_nettype wire

/* tb/coreTrace.mem */
// tag_a_b: 1 = instruction (address, word), 2 = writeback (register, value),
// 3 = store (address, data); writebacks and stores in program order
1_00000000_24010005
1_00000004_2402fffd
1_00000008_00221821
1_0000000c_00612023
1_00000010_00812824
1_00000014_00413025
1_00000018_00c13826
1_0000001c_00204027
1_00000020_0041482a
1_00000024_0041502b
1_00000028_00015900
1_0000002c_00026702
1_00000030_3c0d1234
1_00000034_35ad8765
1_00000038_304eff0f
1_0000003c_284ffffe
1_00000040_ac0d0010
1_00000044_8c100010
1_00000048_02018821
1_0000004c_8c120020
1_00000050_ac120024
1_00000054_10210002
1_00000058_24130019
1_0000005c_24140bad
1_00000060_14210003
1_00000064_24140020
1_00000068_14220002
1_0000006c_24150021
1_00000070_24160bad
1_00000074_10220002
1_00000078_24160022
1_0000007c_0c000024
1_00000080_24170023
1_00000084_08000028
1_00000088_24190025
1_0000008c_241a0bad
1_00000090_24180024
1_00000094_03e00008
1_00000098_ac180028
1_0000009c_241a0bad
1_000000a0_08000028
1_000000a4_00000000
// ALU, forwarding at distance 1 and 2
2_00000001_00000005
2_00000002_fffffffd
2_00000003_00000002
2_00000004_fffffffd
2_00000005_00000005
2_00000006_fffffffd
2_00000007_fffffff8
2_00000008_fffffffa
2_00000009_00000001
2_0000000a_00000000
2_0000000b_00000050
2_0000000c_0000000f
2_0000000d_12340000
2_0000000d_12348765
2_0000000e_0000ff0d
2_0000000f_00000001
// loads and load-use
2_00000010_12348765
2_00000011_1234876a
2_00000012_c0de0020
// delay slots, jal link, jump targets
2_00000013_00000019
2_00000014_00000020
2_00000015_00000021
2_00000016_00000022
2_0000001f_00000084
2_00000017_00000023
2_00000018_00000024
2_00000019_00000025
3_00000010_12348765
3_00000024_c0de0020
3_00000028_00000024

/* tb/mipsCoreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module mipsCoreTb import mipsPkg::*; ();
    localparam int clkPeriod     = 100;
    localparam int traceDepth    = 128;
    localparam int resetCycles   = 4;
    localparam int timeoutCycles = 1000;
    localparam int drainCycles   = 20;  // lets stray writebacks surface

    logic        clk;
    logic        arstN;
    word_t       imemAddr, imemData;
    word_t       dmemAddr, dmemWdata, dmemRdata;
    logic        dmemWe;
    logic        wbValid;
    regAddr_t    wbAddr;
    word_t       wbData;
    logic [67:0] trace [traceDepth];  // tag, field a, field b
    word_t       imem [64];
    word_t       dmem [256];
    int          wbTotal, storeTotal;
    int          wbSeen, storeSeen;
    int          monErrors, tbErrors;
    int          cycles;

    // unwritten data words read back as a function of their address
    function automatic word_t fillWord(input word_t addr);
        return addr ^ 32'hC0DE_0000;
    endfunction

    assign imemData  = imem[imemAddr[7:2]];
    assign dmemRdata = dmem[dmemAddr[9:2]];

    mipsCore mipsCore_i (
        .clk (clk), .arstN (arstN),
        .imemAddr (imemAddr), .imemData (imemData),
        .dmemAddr (dmemAddr), .dmemWdata (dmemWdata), .dmemWe (dmemWe),
        .dmemRdata (dmemRdata),
        .wbValid (wbValid), .wbAddr (wbAddr), .wbData (wbData)
    );

    coreMonitor #(.traceDepth (traceDepth)) coreMonitor_i (
        .clk (clk), .arstN (arstN), .trace (trace), .imemAddr (imemAddr),
        .wbValid (wbValid), .wbAddr (wbAddr), .wbData (wbData),
        .dmemWe (dmemWe), .dmemAddr (dmemAddr), .dmemWdata (dmemWdata),
        .wbSeen (wbSeen), .storeSeen (storeSeen), .errCount (monErrors)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (arstN && dmemWe) begin
            dmem[dmemAddr[9:2]] <= dmemWdata; // lands before the next MEM cycle
        end
    end

    initial begin
        arstN      = 1'b0;
        tbErrors   = 0;
        wbTotal    = 0;
        storeTotal = 0;
        cycles     = 0;
        for (int i = 0; i < traceDepth; i++) begin
            trace[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;                     // nop
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fillWord(word_t'(i * 4));
        end
        $readmemh("tb/coreTrace.mem", trace);
        for (int i = 0; i < traceDepth; i++) begin
            case (trace[i][67:64])
                4'h1: imem[trace[i][39:34]] = trace[i][31:0];
                4'h2: wbTotal++;
                4'h3: storeTotal++;
                default: ;
            endcase
        end
        if (wbTotal == 0) begin
            $display("trace file holds no expected writebacks");
            tbErrors++;
        end

        for (int i = 0; i < resetCycles; i++) begin
            @(negedge clk);
        end
        arstN = 1'b1;

        while ((wbSeen < wbTotal || storeSeen < storeTotal) && cycles < timeoutCycles) begin
            @(negedge clk);
            cycles++;
        end
        if (wbSeen < wbTotal || storeSeen < storeTotal) begin
            $display("timeout: saw %0d of %0d writebacks and %0d of %0d stores",
                     wbSeen, wbTotal, storeSeen, storeTotal);
            tbErrors++;
        end
        for (int i = 0; i < drainCycles; i++) begin
            @(negedge clk);
        end

        $display("monitor errors: %0d, testbench errors: %0d", monErrors, tbErrors);
        if (monErrors == 0 && tbErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
